// ==== flist.f ====
rtl/main_pkg.sv
rtl/region_mapper.sv
rtl/main_chip_sel.sv
rtl/cabinet_io.sv
rtl/bus_ack.sv
rtl/main_bus.sv
tests/tb_clk_gen.sv
tests/tb_main_bus.sv

// ==== rtl/bus_ack.sv ====
`timescale 1ns/100ps

module bus_ack #(
    parameter int ack_wait = 3
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        as_n,
    input  logic                        rom_cs,
    input  logic                        char_cs,
    input  logic                        vram_cs,
    input  logic                        ram_cs,
    input  logic                        objram_cs,
    input  logic                        pal_cs,
    input  logic                        io_cs,
    input  logic [main_pkg::data_w-1:0] ram_data,
    input  logic [main_pkg::data_w-1:0] rom_data,
    input  logic [main_pkg::data_w-1:0] char_dout,
    input  logic [main_pkg::data_w-1:0] pal_dout,
    input  logic [main_pkg::data_w-1:0] obj_dout,
    input  logic [7:0]                  cab_dout,
    input  logic                        ram_ok,
    input  logic                        rom_ok,
    output logic [main_pkg::data_w-1:0] cpu_din,
    output logic                        dtack_n
);

    localparam int cnt_w = $clog2(ack_wait + 1);

    logic [cnt_w-1:0] cnt;
    logic             slow_sel;
    logic             slow_busy;
    logic             slow_done;
    logic             ack_now;

    assign slow_sel  = rom_cs | ram_cs | vram_cs;
    assign slow_busy = (rom_cs & ~rom_ok) | ((ram_cs | vram_cs) & ~ram_ok);

    // Slow memories ack one cycle after their data was captured
    assign ack_now = slow_sel ? slow_done : cnt == cnt_w'(ack_wait);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            cnt       <= '0;
            slow_done <= 1'b0;
            dtack_n   <= 1'b1;
        end else if (as_n) begin
            cnt       <= '0;
            slow_done <= 1'b0;
            dtack_n   <= 1'b1;
        end else begin
            if (cnt != cnt_w'(ack_wait)) begin
                cnt <= cnt + 1'b1;
            end
            if (slow_sel && !slow_busy) begin
                slow_done <= 1'b1;
            end
            dtack_n <= dtack_n & ~ack_now;  // Held low until as_n rises
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            cpu_din <= '1;
        end else if (ram_cs || vram_cs) begin
            cpu_din <= ram_data;
        end else if (rom_cs) begin
            cpu_din <= rom_data;
        end else if (char_cs) begin
            cpu_din <= char_dout;
        end else if (pal_cs) begin
            cpu_din <= pal_dout;
        end else if (objram_cs) begin
            cpu_din <= obj_dout;
        end else if (io_cs) begin
            cpu_din <= {8'hff, cab_dout};
        end
        // Unmapped access keeps the last word
    end

endmodule

// ==== rtl/cabinet_io.sv ====
`timescale 1ns/100ps

module cabinet_io (
    input  logic       clk,
    input  logic       rst,
    input  logic       io_cs,
    input  logic       tbank_cs,
    input  logic       ldsw_n,
    input  logic [1:0] io_page,     // A13..A12
    input  logic [1:0] io_reg,      // A2..A1
    input  logic [7:0] wr_data,
    input  logic [7:0] joystick1,
    input  logic [7:0] joystick2,
    input  logic [1:0] start_button,
    input  logic [1:0] coin_input,
    input  logic       service,
    input  logic       dip_test,
    input  logic [7:0] dipsw_a,
    input  logic [7:0] dipsw_b,
    output logic [7:0] cab_dout,
    output logic       flip,
    output logic       video_en,
    output logic [5:0] tile_bank
);

    // Reorder joystick bits to the board's input port layout
    function automatic logic [7:0] sort_joy(input logic [7:0] joy);
        sort_joy = {joy[1:0], joy[3:2], joy[7], joy[5:4], joy[6]};
    endfunction

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            cab_dout <= 8'hff;
        end else begin
            cab_dout <= 8'hff;  // Idle bus reads as ones
            if (io_cs) begin
                case (io_page)
                    2'd1: begin
                        case (io_reg)
                            2'd0: cab_dout <= {2'b11, start_button, service, dip_test,
                                               coin_input};
                            2'd1: cab_dout <= sort_joy(joystick1);
                            2'd3: cab_dout <= sort_joy(joystick2);
                            default: ;
                        endcase
                    end
                    2'd2: cab_dout <= io_reg[0] ? dipsw_a : dipsw_b;
                    default: ;
                endcase
            end
        end
    end

    // Video control and tile bank registers take low byte writes
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            flip      <= 1'b0;
            video_en  <= 1'b1;
            tile_bank <= '0;
        end else begin
            if (io_cs && io_page == 2'd0 && !ldsw_n) begin
                flip     <= wr_data[6];
                video_en <= wr_data[5];
            end
            if (tbank_cs && !ldsw_n) begin
                if (io_reg[0]) begin
                    tile_bank[5:3] <= wr_data[2:0];
                end else begin
                    tile_bank[2:0] <= wr_data[2:0];
                end
            end
        end
    end

endmodule

// ==== rtl/main_bus.sv ====
`timescale 1ns/100ps

module main_bus #(
    parameter int ack_wait = 3
) (
    input  logic                        clk,
    input  logic                        rst,
    // CPU bus
    input  logic [main_pkg::addr_w:1]   addr,
    input  logic                        as_n,
    input  logic                        rnw,
    input  logic                        uds_n,
    input  logic                        lds_n,
    input  logic [main_pkg::data_w-1:0] cpu_dout,
    output logic [main_pkg::data_w-1:0] cpu_din,
    output logic                        dtack_n,
    output logic                        udsw_n,
    output logic                        ldsw_n,
    // Region mapper programming
    input  logic                        map_we,
    input  logic [main_pkg::reg_w-1:0]  map_sel,
    input  logic [7:0]                  map_data,
    // Cabinet
    input  logic [7:0]                  joystick1,
    input  logic [7:0]                  joystick2,
    input  logic [1:0]                  start_button,
    input  logic [1:0]                  coin_input,
    input  logic                        service,
    input  logic                        dip_test,
    input  logic [7:0]                  dipsw_a,
    input  logic [7:0]                  dipsw_b,
    // ROM
    output logic                        rom_cs,
    output logic [17:0]                 rom_addr,
    input  logic [main_pkg::data_w-1:0] rom_data,
    input  logic                        rom_ok,
    // Work RAM and VRAM
    output logic                        ram_cs,
    output logic                        vram_cs,
    input  logic [main_pkg::data_w-1:0] ram_data,
    input  logic                        ram_ok,
    // Video memories
    output logic                        char_cs,
    output logic                        pal_cs,
    output logic                        objram_cs,
    input  logic [main_pkg::data_w-1:0] char_dout,
    input  logic [main_pkg::data_w-1:0] pal_dout,
    input  logic [main_pkg::data_w-1:0] obj_dout,
    // Video control
    output logic                        flip,
    output logic                        video_en,
    output logic [5:0]                  tile_bank
);
    import main_pkg::*;

    logic [region_cnt-1:0] active;
    logic                  bus_n;
    logic                  io_cs;
    logic                  tbank_cs;
    logic [7:0]            cab_dout;

    assign udsw_n   = rnw | uds_n;
    assign ldsw_n   = rnw | lds_n;
    assign bus_n    = as_n | (uds_n & lds_n);
    assign rom_addr = {active[1], addr[17:1]};  // 512kB window

    region_mapper u_mapper (
        .clk      ( clk          ),
        .rst      ( rst          ),
        .map_we   ( map_we       ),
        .map_sel  ( map_sel      ),
        .map_data ( map_data     ),
        .addr_hi  ( addr[23:16]  ),
        .active   ( active       )
    );

    main_chip_sel u_chip_sel (
        .clk       ( clk        ),
        .rst       ( rst        ),
        .as_n      ( as_n       ),
        .bus_n     ( bus_n      ),
        .rnw       ( rnw        ),
        .addr_16   ( addr[16]   ),
        .active    ( active     ),
        .rom_cs    ( rom_cs     ),
        .char_cs   ( char_cs    ),
        .vram_cs   ( vram_cs    ),
        .ram_cs    ( ram_cs     ),
        .objram_cs ( objram_cs  ),
        .pal_cs    ( pal_cs     ),
        .io_cs     ( io_cs      ),
        .tbank_cs  ( tbank_cs   )
    );

    cabinet_io u_cabinet (
        .clk          ( clk           ),
        .rst          ( rst           ),
        .io_cs        ( io_cs         ),
        .tbank_cs     ( tbank_cs      ),
        .ldsw_n       ( ldsw_n        ),
        .io_page      ( addr[13:12]   ),
        .io_reg       ( addr[2:1]     ),
        .wr_data      ( cpu_dout[7:0] ),
        .joystick1    ( joystick1     ),
        .joystick2    ( joystick2     ),
        .start_button ( start_button  ),
        .coin_input   ( coin_input    ),
        .service      ( service       ),
        .dip_test     ( dip_test      ),
        .dipsw_a      ( dipsw_a       ),
        .dipsw_b      ( dipsw_b       ),
        .cab_dout     ( cab_dout      ),
        .flip         ( flip          ),
        .video_en     ( video_en      ),
        .tile_bank    ( tile_bank     )
    );

    bus_ack #(
        .ack_wait ( ack_wait )
    ) u_ack (
        .clk       ( clk        ),
        .rst       ( rst        ),
        .as_n      ( as_n       ),
        .rom_cs    ( rom_cs     ),
        .char_cs   ( char_cs    ),
        .vram_cs   ( vram_cs    ),
        .ram_cs    ( ram_cs     ),
        .objram_cs ( objram_cs  ),
        .pal_cs    ( pal_cs     ),
        .io_cs     ( io_cs      ),
        .ram_data  ( ram_data   ),
        .rom_data  ( rom_data   ),
        .char_dout ( char_dout  ),
        .pal_dout  ( pal_dout   ),
        .obj_dout  ( obj_dout   ),
        .cab_dout  ( cab_dout   ),
        .ram_ok    ( ram_ok     ),
        .rom_ok    ( rom_ok     ),
        .cpu_din   ( cpu_din    ),
        .dtack_n   ( dtack_n    )
    );

endmodule

// ==== rtl/main_chip_sel.sv ====
`timescale 1ns/100ps

module main_chip_sel (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            as_n,
    input  logic                            bus_n,
    input  logic                            rnw,
    input  logic                            addr_16,
    input  logic [main_pkg::region_cnt-1:0] active,
    output logic                            rom_cs,
    output logic                            char_cs,
    output logic                            vram_cs,
    output logic                            ram_cs,
    output logic                            objram_cs,
    output logic                            pal_cs,
    output logic                            io_cs,
    output logic                            tbank_cs
);
    import main_pkg::*;

    logic [7:0] sel_d;
    logic [7:0] sel_q;

    always_comb begin
        sel_d = '0;
        if (!as_n) begin
            sel_d[0] = |active[2:0] && rnw;                // ROM reads only
            sel_d[1] = active[reg_vram] && addr_16;        // Char half of VRAM window
            // RAM requests restart whenever bus_n toggles
            sel_d[2] = !bus_n && active[reg_vram] && !addr_16;
            sel_d[3] = !bus_n && active[reg_ram];
            sel_d[4] = active[reg_oram];
            sel_d[5] = active[reg_pal];
            sel_d[6] = active[reg_io];
            sel_d[7] = active[2] && !rnw;                  // Writes to ROM bank 2
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            sel_q <= '0;
        end else begin
            sel_q <= sel_d;
        end
    end

    assign rom_cs    = sel_q[0];
    assign char_cs   = sel_q[1];
    assign vram_cs   = sel_q[2];
    assign ram_cs    = sel_q[3];
    assign objram_cs = sel_q[4];
    assign pal_cs    = sel_q[5];
    assign io_cs     = sel_q[6];
    assign tbank_cs  = sel_q[7];

endmodule

// ==== rtl/main_pkg.sv ====
package main_pkg;

    // Bus widths
    localparam int addr_w = 23;     // Word address A23..A1
    localparam int data_w = 16;

    // Region mapper
    localparam int region_cnt = 8;
    localparam int reg_w      = 3;  // Region index width

    // Regions 0 to 2 hold program ROM
    localparam logic [reg_w-1:0] reg_ram  = 3'd3;
    localparam logic [reg_w-1:0] reg_oram = 3'd4;
    localparam logic [reg_w-1:0] reg_vram = 3'd5;
    localparam logic [reg_w-1:0] reg_pal  = 3'd6;
    localparam logic [reg_w-1:0] reg_io   = 3'd7;

    // Power-up base byte of each region, compared against A23..A16
    localparam logic [7:0] default_base [region_cnt] = '{
        8'h00,  // ROM bank 0
        8'h01,  // ROM bank 1
        8'h02,  // ROM bank 2 and tile bank writes
        8'hff,  // Work RAM
        8'h44,  // Object RAM
        8'h40,  // Tile/text RAM
        8'h84,  // Palette
        8'hc4   // Cabinet I/O
    };

endpackage

// ==== rtl/region_mapper.sv ====
`timescale 1ns/100ps

module region_mapper (
    input  logic                            clk,
    input  logic                            rst,
    // Base programming writes one region per cycle
    input  logic                            map_we,
    input  logic [main_pkg::reg_w-1:0]      map_sel,
    input  logic [7:0]                      map_data,
    // Upper address byte A23..A16
    input  logic [7:0]                      addr_hi,
    output logic [main_pkg::region_cnt-1:0] active
);
    import main_pkg::*;

    logic [7:0] base [region_cnt];

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            for (int i = 0; i < region_cnt; i++) begin
                base[i] <= default_base[i];
            end
        end else if (map_we) begin
            base[map_sel] <= map_data;  // Other regions keep their base
        end
    end

    // Address match per region
    always_comb begin
        for (int i = 0; i < region_cnt; i++) begin
            active[i] = base[i] == addr_hi;
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps --top-module tb_main_bus \
    -f flist.f -o tb_main_bus > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build error, see build.log"
    exit 1
fi

./obj_dir/tb_main_bus > sim.log 2>&1
if [ $? -ne 0 ]; then
    cat sim.log
    echo "Simulation ended abnormally, see sim.log"
    exit 1
fi

cat sim.log
if grep -q "Testbench failed" sim.log; then
    exit 1
fi
exit 0

// ==== tests/tb_clk_gen.sv ====
`timescale 1ns/100ps

module tb_clk_gen #(
    parameter int period     = 40,
    parameter int rst_cycles = 3
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (rst_cycles) @(posedge clk);
        #2 rst = 1'b0;  // Released off the clock edge
    end

endmodule

// ==== tests/tb_main_bus.sv ====
`timescale 1ns/100ps

module tb_main_bus;

    localparam int ack_wait    = 3;
    localparam int access_cnt  = 40;
    localparam int cycle_limit = 40 * access_cnt + 20;  // Reset and mapper writes on top

    logic        clk;
    logic        rst;
    logic [23:1] addr;
    logic        as_n;
    logic        rnw;
    logic        uds_n;
    logic        lds_n;
    logic [15:0] cpu_dout;
    logic [15:0] cpu_din;
    logic        dtack_n;
    logic        udsw_n;
    logic        ldsw_n;
    logic        map_we;
    logic [2:0]  map_sel;
    logic [7:0]  map_data;
    logic [7:0]  joystick1;
    logic [7:0]  joystick2;
    logic [1:0]  start_button;
    logic [1:0]  coin_input;
    logic        service;
    logic        dip_test;
    logic [7:0]  dipsw_a;
    logic [7:0]  dipsw_b;
    logic        rom_cs;
    logic [17:0] rom_addr;
    logic [15:0] rom_data;
    logic        rom_ok = 1'b0;
    logic        ram_cs;
    logic        vram_cs;
    logic [15:0] ram_data;
    logic        ram_ok = 1'b0;
    logic        char_cs;
    logic        pal_cs;
    logic        objram_cs;
    logic [15:0] char_dout;
    logic [15:0] pal_dout;
    logic [15:0] obj_dout;
    logic        flip;
    logic        video_en;
    logic [5:0]  tile_bank;

    integer      seed = 56;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          rom_wait = -1;
    int          ram_wait = -1;
    int          ram_cs_cycles = 0;
    int          ack_cycles;
    logic [7:0]  base [8];             // Expected region bases
    logic        exp_flip;
    logic        exp_video_en;
    logic [5:0]  exp_tile_bank;
    logic [15:0] exp_din;
    logic [15:0] last_din;
    logic        check_din = 1'b0;
    logic        ack_seen = 1'b0;
    string       test_name = "idle";

    tb_clk_gen i_clk_gen (
        .clk ( clk ),
        .rst ( rst )
    );

    main_bus #(
        .ack_wait ( ack_wait )
    ) i_dut (.*);

    // Word contents of the memory models
    function automatic logic [15:0] mem_word(input logic [3:0] salt, input logic [23:0] key);
        mem_word = (key[16:1] * 16'd40503) ^ {salt, salt, salt, salt} ^ {8'd0, key[23:16]};
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [31:0] r;
        r = $random(seed);
        return r[7:0];
    endfunction

    function automatic logic [7:0] joy_port(input logic [7:0] j);
        logic [7:0] s;
        s[7] = j[1];
        s[6] = j[0];
        s[5] = j[3];
        s[4] = j[2];
        s[3] = j[7];
        s[2] = j[5];
        s[1] = j[4];
        s[0] = j[6];
        return s;
    endfunction

    function automatic logic [7:0] cab_ref(input logic [23:1] a);
        logic [7:0] v;
        v = 8'hff;
        if (a[13:12] == 2'd1) begin
            if (a[2:1] == 2'd0) v = {2'b11, start_button, service, dip_test, coin_input};
            else if (a[2:1] == 2'd1) v = joy_port(joystick1);
            else if (a[2:1] == 2'd3) v = joy_port(joystick2);
        end else if (a[13:12] == 2'd2) begin
            v = a[1] ? dipsw_a : dipsw_b;
        end
        return v;
    endfunction

    // Expected cpu_din after an access with a data strobe
    function automatic logic [15:0] ref_din(input logic [23:1] a, input logic rd,
                                            input logic [15:0] prev);
        logic [7:0] hi;
        hi = a[23:16];
        if (hi == base[3] || (hi == base[5] && !a[16])) return mem_word(4'h2, {a, 1'b0});
        if (rd && (hi == base[0] || hi == base[1] || hi == base[2]))
            return mem_word(4'h1, {5'd0, hi == base[1], a[17:1], 1'b0});
        if (hi == base[5]) return mem_word(4'h3, {a, 1'b0});
        if (hi == base[6]) return mem_word(4'h4, {a, 1'b0});
        if (hi == base[4]) return mem_word(4'h5, {a, 1'b0});
        if (hi == base[7]) return {8'hff, cab_ref(a)};
        return prev;
    endfunction

    task automatic check_val(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    assign rom_data  = mem_word(4'h1, {5'd0, rom_addr, 1'b0});
    assign ram_data  = mem_word(4'h2, {addr, 1'b0});
    assign char_dout = mem_word(4'h3, {addr, 1'b0});
    assign pal_dout  = mem_word(4'h4, {addr, 1'b0});
    assign obj_dout  = mem_word(4'h5, {addr, 1'b0});

    // ROM answers after 0 to 5 cycles
    always @(posedge clk) begin
        #2;
        if (!rom_cs) begin
            rom_ok = 1'b0;
            rom_wait = -1;
        end else if (rom_wait < 0) begin
            rom_wait = int'(rand_byte() % 8'd6);
            rom_ok = rom_wait == 0;
        end else if (rom_wait > 0) begin
            rom_wait--;
            rom_ok = rom_wait == 0;
        end
    end

    always @(posedge clk) begin
        #2;
        if (!(ram_cs || vram_cs)) begin
            ram_ok = 1'b0;
            ram_wait = -1;
        end else if (ram_wait < 0) begin
            ram_wait = int'(rand_byte() % 8'd6);
            ram_ok = ram_wait == 0;
        end else if (ram_wait > 0) begin
            ram_wait--;
            ram_ok = ram_wait == 0;
        end
    end

    always @(negedge clk) begin
        if (ram_cs) ram_cs_cycles++;
    end

    // One comparison per data acknowledge
    always @(negedge clk) begin
        if (rst || dtack_n) begin
            ack_seen = 1'b0;
        end else if (!ack_seen) begin
            ack_seen = 1'b1;
            if (check_din) check_val({test_name, " data"}, 32'(exp_din), 32'(cpu_din));
            check_val({test_name, " write strobes"},
                      32'({!(!rnw && !uds_n), !(!rnw && !lds_n)}), 32'({udsw_n, ldsw_n}));
            check_val({test_name, " video regs"}, 32'({exp_flip, exp_video_en, exp_tile_bank}),
                      32'({flip, video_en, tile_bank}));
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout: no end of test after %0d cycles, %0d errors so far",
                     cycle_limit, errors);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic set_base(input logic [2:0] sel, input logic [7:0] value);
        @(posedge clk);
        #2;
        map_we   = 1'b1;
        map_sel  = sel;
        map_data = value;
        base[sel] = value;
        @(posedge clk);
        #2;
        map_we = 1'b0;
    endtask

    // One bus cycle; strobes_n is {uds_n, lds_n}
    task automatic bus_access(input string name, input logic [23:0] byte_addr, input logic rd,
                              input logic [1:0] strobes_n, input logic [15:0] wdata);
        logic [23:1] a;
        a = byte_addr[23:1];
        @(posedge clk);
        #2;
        if (!rd && !strobes_n[0]) begin
            if (a[23:16] == base[7] && a[13:12] == 2'd0) begin
                exp_flip     = wdata[6];
                exp_video_en = wdata[5];
            end
            if (a[23:16] == base[2]) begin
                if (a[1]) exp_tile_bank[5:3] = wdata[2:0];
                else exp_tile_bank[2:0] = wdata[2:0];
            end
        end
        exp_din   = ref_din(a, rd, last_din);
        last_din  = exp_din;
        check_din = rd;
        test_name = name;
        addr      = a;
        rnw       = rd;
        uds_n     = strobes_n[1];
        lds_n     = strobes_n[0];
        cpu_dout  = wdata;
        as_n      = 1'b0;
        @(posedge clk);   // First edge with as_n low
        ack_cycles = 0;
        @(negedge clk);
        while (dtack_n) begin
            ack_cycles++;
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        as_n  = 1'b1;
        uds_n = 1'b1;
        lds_n = 1'b1;
        rnw   = 1'b1;
    endtask

    initial begin
        logic [7:0] stim;
        int         ram_before;
        addr = '0;
        as_n = 1'b1;
        rnw = 1'b1;
        uds_n = 1'b1;
        lds_n = 1'b1;
        cpu_dout = '0;
        map_we = 1'b0;
        map_sel = '0;
        map_data = '0;
        joystick1 = '1;
        joystick2 = '1;
        start_button = '1;
        coin_input = '1;
        service = 1'b1;
        dip_test = 1'b1;
        dipsw_a = '1;
        dipsw_b = '1;
        base = '{8'h00, 8'h01, 8'h02, 8'hff, 8'h44, 8'h40, 8'h84, 8'hc4};
        exp_flip = 1'b0;
        exp_video_en = 1'b1;
        exp_tile_bank = '0;
        last_din = 16'hffff;
        wait (!rst);
        @(negedge clk);

        check_val("reset video", 32'({flip, video_en, tile_bank}), 32'({1'b0, 1'b1, 6'd0}));
        check_val("reset selects", 32'd0,
                  32'({rom_cs, ram_cs, vram_cs, char_cs, pal_cs, objram_cs}));
        check_val("reset bus", 32'h1ffff, 32'({dtack_n, cpu_din}));
        bus_access("rom bank 0 read", 24'h001234, 1'b1, 2'b00, 16'h0);
        bus_access("rom bank 1 read", 24'h01abcc, 1'b1, 2'b00, 16'h0);
        bus_access("rom bank 2 read", 24'h02fffe, 1'b1, 2'b00, 16'h0);

        bus_access("ram read", 24'hff0010, 1'b1, 2'b00, 16'h0);
        bus_access("ram upper write", 24'hff0020, 1'b0, 2'b01, 16'h1234);
        bus_access("ram lower write", 24'hff0022, 1'b0, 2'b10, 16'h5678);
        bus_access("ram word read", 24'hff8000, 1'b1, 2'b00, 16'h0);
        bus_access("vram read", 24'h400100, 1'b1, 2'b00, 16'h0);
        bus_access("vram write", 24'h40fffe, 1'b0, 2'b00, 16'hbeef);
        set_base(3'd5, 8'h41);  // Window moves up so A16 selects char
        bus_access("char read", 24'h410100, 1'b1, 2'b00, 16'h0);
        set_base(3'd5, 8'h40);
        bus_access("pal read", 24'h840042, 1'b1, 2'b00, 16'h0);
        bus_access("objram read", 24'h440200, 1'b1, 2'b00, 16'h0);

        for (int n = 0; n < 3; n++) begin
            stim = rand_byte();
            start_button = stim[1:0];
            coin_input = stim[3:2];
            service = stim[4];
            dip_test = stim[5];
            joystick1 = rand_byte();
            joystick2 = rand_byte();
            dipsw_a = rand_byte();
            dipsw_b = rand_byte();
            bus_access("system byte", 24'hc41000, 1'b1, 2'b00, 16'h0);
            bus_access("joystick 1", 24'hc41002, 1'b1, 2'b00, 16'h0);
            bus_access("joystick 2", 24'hc41006, 1'b1, 2'b00, 16'h0);
            bus_access("empty input", 24'hc41004, 1'b1, 2'b00, 16'h0);
            bus_access("dip a", 24'hc42002, 1'b1, 2'b00, 16'h0);
            bus_access("dip b", 24'hc42000, 1'b1, 2'b00, 16'h0);
        end

        bus_access("video write", 24'hc40000, 1'b0, 2'b10, 16'h0040);
        bus_access("video upper write", 24'hc40000, 1'b0, 2'b01, 16'h0020);
        bus_access("tile bank low", 24'h020000, 1'b0, 2'b10, 16'h0005);
        bus_access("tile bank high", 24'h020002, 1'b0, 2'b10, 16'h0003);
        bus_access("tile bank upper", 24'h020002, 1'b0, 2'b01, 16'h0007);
        bus_access("video restore", 24'hc40000, 1'b0, 2'b00, 16'h0020);

        bus_access("pal before unmapped", 24'h840010, 1'b1, 2'b00, 16'h0);
        bus_access("unmapped read", 24'h900000, 1'b1, 2'b00, 16'h0);
        check_val("unmapped ack delay", 32'(ack_wait), 32'(ack_cycles));
        set_base(3'd3, 8'h20);
        ram_before = ram_cs_cycles;
        bus_access("old ram base", 24'hff0010, 1'b1, 2'b00, 16'h0);
        check_val("old ram base select", 32'(ram_before), 32'(ram_cs_cycles));
        bus_access("new ram base", 24'h200010, 1'b1, 2'b00, 16'h0);
        check_val("new ram base select", 32'd1, 32'(ram_cs_cycles > ram_before));

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
